// ==== Makefile ====
SIM = obj_dir/Vtb_mem_subsys

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Simulation passed"

$(SIM): verilog.f $(wildcard common/*.sv design/*.sv design/*/*.sv verification/*.sv verification/*.svh)
	verilator --binary --timing --assert -f verilog.f --top-module tb_mem_subsys

clean:
	rm -rf obj_dir

// ==== common/mem_pkg.sv ====
// memory subsystem package
// widths, window map, response codes and payload types shared by all blocks

package mem_pkg;

   localparam int ADDR_W = 32;
   localparam int DATA_W = 64;
   localparam int STRB_W = DATA_W / 8;

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] data_t;
   typedef logic [STRB_W-1:0] strb_t;

   // W channel payload, data in the upper bits
   typedef struct packed {
      data_t data;
      strb_t strb;
   } w_req_t;

   typedef logic [1:0] resp_t;

   localparam resp_t RESP_OKAY   = 2'b00;
   localparam resp_t RESP_DECERR = 2'b11;

   // window map, sizes cut down for simulation
   localparam addr_t BOOT_BASE   = 32'h4000_0000;
   localparam addr_t SHARED_BASE = 32'h4200_0000;
   localparam addr_t MAIN_BASE   = 32'h8000_0000; // DRAM stand-in

   localparam int BOOT_WORDS   = 512;
   localparam int SHARED_WORDS = 512;
   localparam int MAIN_WORDS   = 2048;

   localparam addr_t BOOT_BYTES   = addr_t'(BOOT_WORDS * 8);
   localparam addr_t SHARED_BYTES = addr_t'(SHARED_WORDS * 8);
   localparam addr_t MAIN_BYTES   = addr_t'(MAIN_WORDS * 8);

   localparam int BOOT_IDX_W   = $clog2(BOOT_WORDS);
   localparam int SHARED_IDX_W = $clog2(SHARED_WORDS);
   localparam int MAIN_IDX_W   = $clog2(MAIN_WORDS);

   typedef enum logic [1:0] {
      REGION_BOOT   = 2'd0,
      REGION_SHARED = 2'd1,
      REGION_MAIN   = 2'd2,
      REGION_NONE   = 2'd3
   } region_e;

   // result queue sizing
   localparam int RESP_DEPTH = 2;
   localparam int RESP_PTR_W = $clog2(RESP_DEPTH);
   localparam int RESP_CNT_W = $clog2(RESP_DEPTH + 2); // room for queue plus one arriving

endpackage

// ==== design/axil_front/axil_front.sv ====
// AXI4-Lite request side
// buffers AW, W and AR, pairs AW with W and picks read or write for issue
// issues only while the response side has room

`timescale 1ns/1ps

module axil_front import mem_pkg::*; (
   input  logic  clk_i,
   input  logic  rst_ni,
   // write address
   input  logic  awvalid_i,
   output logic  awready_o,
   input  addr_t awaddr_i,
   // write data
   input  logic  wvalid_i,
   output logic  wready_o,
   input  data_t wdata_i,
   input  strb_t wstrb_i,
   // read address
   input  logic  arvalid_i,
   output logic  arready_o,
   input  addr_t araddr_i,
   // issue channel toward the router
   input  logic  slot_free_i,
   output logic  issue_valid_o,
   output logic  issue_we_o,
   output addr_t issue_addr_o,
   output data_t issue_wdata_o,
   output strb_t issue_wstrb_o
);

   w_req_t w_in;
   w_req_t w_head;
   addr_t  aw_head;
   addr_t  ar_head;
   logic   aw_valid;
   logic   w_valid;
   logic   ar_valid;
   logic   wr_elig;
   logic   rd_elig;
   logic   grant_wr;
   logic   last_wr_q; // last issue was a write

   assign w_in.data = wdata_i;
   assign w_in.strb = wstrb_i;

   axil_req_slice #(.payload_t(addr_t)) aw_slice (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .in_valid_i  (awvalid_i),
      .in_ready_o  (awready_o),
      .in_data_i   (awaddr_i),
      .out_valid_o (aw_valid),
      .out_ready_i (issue_valid_o & grant_wr),
      .out_data_o  (aw_head)
   );

   axil_req_slice #(.payload_t(w_req_t)) w_slice (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .in_valid_i  (wvalid_i),
      .in_ready_o  (wready_o),
      .in_data_i   (w_in),
      .out_valid_o (w_valid),
      .out_ready_i (issue_valid_o & grant_wr),
      .out_data_o  (w_head)
   );

   axil_req_slice #(.payload_t(addr_t)) ar_slice (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .in_valid_i  (arvalid_i),
      .in_ready_o  (arready_o),
      .in_data_i   (araddr_i),
      .out_valid_o (ar_valid),
      .out_ready_i (issue_valid_o & ~grant_wr),
      .out_data_o  (ar_head)
   );

   assign wr_elig = aw_valid & w_valid; // need both halves of a write
   assign rd_elig = ar_valid;

   // alternate when both are waiting
   assign grant_wr = wr_elig & (~rd_elig | ~last_wr_q);

   assign issue_valid_o = slot_free_i & (wr_elig | rd_elig);
   assign issue_we_o    = grant_wr;
   assign issue_addr_o  = grant_wr ? aw_head : ar_head;
   assign issue_wdata_o = w_head.data;
   assign issue_wstrb_o = w_head.strb;

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         last_wr_q <= 1'b0;
      end else if (issue_valid_o) begin
         last_wr_q <= grant_wr;
      end
   end

endmodule

// ==== design/axil_front/axil_req_slice.sv ====
// request slice
// one-entry skid buffer on a valid/ready channel, ready comes from a flop

`timescale 1ns/1ps

module axil_req_slice #(
   parameter type payload_t = logic
) (
   input  logic     clk_i,
   input  logic     rst_ni,
   input  logic     in_valid_i,
   output logic     in_ready_o,
   input  payload_t in_data_i,
   output logic     out_valid_o,
   input  logic     out_ready_i,
   output payload_t out_data_o
);

   logic     main_valid_q;
   logic     spare_valid_q;
   payload_t main_q;
   payload_t spare_q;
   logic     accept;
   logic     main_load;

   assign in_ready_o  = ~spare_valid_q;   // registered
   assign accept      = in_valid_i & in_ready_o;
   assign main_load   = ~main_valid_q | out_ready_i; // main empty or drained this cycle
   assign out_valid_o = main_valid_q;
   assign out_data_o  = main_q;

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         main_valid_q  <= 1'b0;
         spare_valid_q <= 1'b0;
      end else if (main_load) begin
         main_valid_q  <= spare_valid_q | accept;
         spare_valid_q <= 1'b0;
      end else if (accept) begin
         spare_valid_q <= 1'b1; // output stalled, park it
      end
   end

   always_ff @(posedge clk_i) begin
      if (main_load) begin
         main_q <= spare_valid_q ? spare_q : in_data_i;
      end else if (accept) begin
         spare_q <= in_data_i;
      end
   end

   // a stalled output must not change under the consumer
   property p_hold_stable;
      @(posedge clk_i) disable iff (!rst_ni)
         (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_data_o));
   endproperty
   a_hold_stable: assert property (p_hold_stable);

endmodule

// ==== design/axil_resp.sv ====
// response side
// in-order result queue feeding the B and R channels
// reports room for another issue through slot_free

`timescale 1ns/1ps

module axil_resp import mem_pkg::*; (
   input  logic  clk_i,
   input  logic  rst_ni,
   input  logic  res_valid_i,
   input  logic  res_we_i,
   input  logic  res_err_i,
   input  data_t res_rdata_i,
   output logic  slot_free_o,
   // write response
   output logic  bvalid_o,
   input  logic  bready_i,
   output resp_t bresp_o,
   // read data
   output logic  rvalid_o,
   input  logic  rready_i,
   output data_t rdata_o,
   output resp_t rresp_o
);

   logic                  we_q    [RESP_DEPTH];
   logic                  err_q   [RESP_DEPTH];
   data_t                 rdata_q [RESP_DEPTH];
   logic [RESP_PTR_W-1:0] wr_ptr_q;
   logic [RESP_PTR_W-1:0] rd_ptr_q;
   logic [RESP_CNT_W-1:0] cnt_q;
   logic [RESP_CNT_W-1:0] level; // queued plus the result now arriving
   logic                  head_valid;
   logic                  pop;

   assign head_valid = (cnt_q != '0);
   assign bvalid_o   = head_valid & we_q[rd_ptr_q];
   assign rvalid_o   = head_valid & ~we_q[rd_ptr_q];
   assign bresp_o    = err_q[rd_ptr_q] ? RESP_DECERR : RESP_OKAY;
   assign rresp_o    = err_q[rd_ptr_q] ? RESP_DECERR : RESP_OKAY;
   assign rdata_o    = rdata_q[rd_ptr_q];
   assign pop        = (bvalid_o & bready_i) | (rvalid_o & rready_i);

   // anything issued earlier is either queued or arriving now
   assign level       = cnt_q + RESP_CNT_W'(res_valid_i);
   assign slot_free_o = level < RESP_CNT_W'(RESP_DEPTH);

   always_ff @(posedge clk_i) begin
      if (res_valid_i) begin
         we_q[wr_ptr_q]    <= res_we_i;
         err_q[wr_ptr_q]   <= res_err_i;
         rdata_q[wr_ptr_q] <= res_rdata_i;
      end
   end

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         cnt_q    <= '0;
      end else begin
         if (res_valid_i) begin
            wr_ptr_q <= (wr_ptr_q == RESP_PTR_W'(RESP_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= (rd_ptr_q == RESP_PTR_W'(RESP_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         end
         cnt_q <= cnt_q + RESP_CNT_W'(res_valid_i) - RESP_CNT_W'(pop);
      end
   end

   // front gating on slot_free keeps a full queue from being written
   a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
      res_valid_i |-> (cnt_q < RESP_CNT_W'(RESP_DEPTH)));

endmodule

// ==== design/bram_bank.sv ====
// BRAM bank
// single-port 64-bit word memory, byte write strobes, one-cycle read

`timescale 1ns/1ps

module bram_bank import mem_pkg::*; #(
   parameter int DEPTH = 512
) (
   input  logic                     clk_i,
   input  logic                     en_i,
   input  logic                     we_i,
   input  logic [$clog2(DEPTH)-1:0] idx_i,
   input  data_t                    wdata_i,
   input  strb_t                    wstrb_i,
   output data_t                    rdata_o
);

   data_t mem [DEPTH];

   always_ff @(posedge clk_i) begin
      if (en_i) begin
         if (we_i) begin
            for (int b = 0; b < STRB_W; b++) begin
               if (wstrb_i[b]) begin
                  mem[idx_i][8*b +: 8] <= wdata_i[8*b +: 8]; // strobed bytes only
               end
            end
         end else begin
            rdata_o <= mem[idx_i];
         end
      end
   end

endmodule

// ==== design/mem_router.sv ====
// memory router
// decodes an issued request to boot, shared or main memory and drives that bank
// the tagged result follows one cycle after the issue

`timescale 1ns/1ps

module mem_router import mem_pkg::*; (
   input  logic  clk_i,
   input  logic  rst_ni,
   input  logic  issue_valid_i,
   input  logic  issue_we_i,
   input  addr_t issue_addr_i,
   input  data_t issue_wdata_i,
   input  strb_t issue_wstrb_i,
   output logic  res_valid_o,
   output logic  res_we_o,
   output logic  res_err_o,
   output data_t res_rdata_o
);

   addr_t   boot_off;
   addr_t   shared_off;
   addr_t   main_off;
   region_e region;
   region_e region_q;
   logic    boot_en;
   logic    shared_en;
   logic    main_en;
   data_t   boot_rdata;
   data_t   shared_rdata;
   data_t   main_rdata;

   // offsets wrap below the base, so one compare covers both ends
   assign boot_off   = issue_addr_i - BOOT_BASE;
   assign shared_off = issue_addr_i - SHARED_BASE;
   assign main_off   = issue_addr_i - MAIN_BASE;

   always_comb begin
      if (boot_off < BOOT_BYTES)          region = REGION_BOOT;
      else if (shared_off < SHARED_BYTES) region = REGION_SHARED;
      else if (main_off < MAIN_BYTES)     region = REGION_MAIN;
      else                                region = REGION_NONE;
   end

   // each bank enables on its own window hit
   assign boot_en   = issue_valid_i & (boot_off < BOOT_BYTES);
   assign shared_en = issue_valid_i & (shared_off < SHARED_BYTES);
   assign main_en   = issue_valid_i & (main_off < MAIN_BYTES);

   bram_bank #(.DEPTH(BOOT_WORDS)) boot_bank (
      .clk_i   (clk_i),
      .en_i    (boot_en),
      .we_i    (issue_we_i),
      .idx_i   (boot_off[BOOT_IDX_W+2:3]),
      .wdata_i (issue_wdata_i),
      .wstrb_i (issue_wstrb_i),
      .rdata_o (boot_rdata)
   );

   bram_bank #(.DEPTH(SHARED_WORDS)) shared_bank (
      .clk_i   (clk_i),
      .en_i    (shared_en),
      .we_i    (issue_we_i),
      .idx_i   (shared_off[SHARED_IDX_W+2:3]),
      .wdata_i (issue_wdata_i),
      .wstrb_i (issue_wstrb_i),
      .rdata_o (shared_rdata)
   );

   bram_bank #(.DEPTH(MAIN_WORDS)) main_bank (
      .clk_i   (clk_i),
      .en_i    (main_en),
      .we_i    (issue_we_i),
      .idx_i   (main_off[MAIN_IDX_W+2:3]),
      .wdata_i (issue_wdata_i),
      .wstrb_i (issue_wstrb_i),
      .rdata_o (main_rdata)
   );

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         res_valid_o <= 1'b0;
         res_we_o    <= 1'b0;
         res_err_o   <= 1'b0;
         region_q    <= REGION_NONE;
      end else begin
         res_valid_o <= issue_valid_i;
         res_we_o    <= issue_we_i;
         res_err_o   <= (region == REGION_NONE);
         region_q    <= region;
      end
   end

   // bank read data lines up with the registered region
   always_comb begin
      res_rdata_o = '0;
      if (!res_err_o && !res_we_o) begin
         case (region_q)
            REGION_BOOT:   res_rdata_o = boot_rdata;
            REGION_SHARED: res_rdata_o = shared_rdata;
            REGION_MAIN:   res_rdata_o = main_rdata;
            default:       res_rdata_o = '0;
         endcase
      end
   end

   // two enables at once would mean overlapping windows
   a_one_bank: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $onehot0({boot_en, shared_en, main_en}));

endmodule

// ==== design/mem_subsys_top.sv ====
// on-chip memory subsystem
// AXI4-Lite slave serving boot, shared debug and main memory windows
// request side, router with banks, response side

`timescale 1ns/1ps

module mem_subsys_top import mem_pkg::*; (
   input  logic  clk_i,
   input  logic  rst_ni,
   input  logic  awvalid_i,
   output logic  awready_o,
   input  addr_t awaddr_i,
   input  logic  wvalid_i,
   output logic  wready_o,
   input  data_t wdata_i,
   input  strb_t wstrb_i,
   output logic  bvalid_o,
   input  logic  bready_i,
   output resp_t bresp_o,
   input  logic  arvalid_i,
   output logic  arready_o,
   input  addr_t araddr_i,
   output logic  rvalid_o,
   input  logic  rready_i,
   output data_t rdata_o,
   output resp_t rresp_o
);

   logic  slot_free;
   logic  issue_valid;
   logic  issue_we;
   addr_t issue_addr;
   data_t issue_wdata;
   strb_t issue_wstrb;
   logic  res_valid;
   logic  res_we;
   logic  res_err;
   data_t res_rdata;

   axil_front i_axil_front (
      .clk_i         (clk_i),
      .rst_ni        (rst_ni),
      .awvalid_i     (awvalid_i),
      .awready_o     (awready_o),
      .awaddr_i      (awaddr_i),
      .wvalid_i      (wvalid_i),
      .wready_o      (wready_o),
      .wdata_i       (wdata_i),
      .wstrb_i       (wstrb_i),
      .arvalid_i     (arvalid_i),
      .arready_o     (arready_o),
      .araddr_i      (araddr_i),
      .slot_free_i   (slot_free),
      .issue_valid_o (issue_valid),
      .issue_we_o    (issue_we),
      .issue_addr_o  (issue_addr),
      .issue_wdata_o (issue_wdata),
      .issue_wstrb_o (issue_wstrb)
   );

   mem_router i_mem_router (
      .clk_i         (clk_i),
      .rst_ni        (rst_ni),
      .issue_valid_i (issue_valid),
      .issue_we_i    (issue_we),
      .issue_addr_i  (issue_addr),
      .issue_wdata_i (issue_wdata),
      .issue_wstrb_i (issue_wstrb),
      .res_valid_o   (res_valid),
      .res_we_o      (res_we),
      .res_err_o     (res_err),
      .res_rdata_o   (res_rdata)
   );

   axil_resp i_axil_resp (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .res_valid_i (res_valid),
      .res_we_i    (res_we),
      .res_err_i   (res_err),
      .res_rdata_i (res_rdata),
      .slot_free_o (slot_free),
      .bvalid_o    (bvalid_o),
      .bready_i    (bready_i),
      .bresp_o     (bresp_o),
      .rvalid_o    (rvalid_o),
      .rready_i    (rready_i),
      .rdata_o     (rdata_o),
      .rresp_o     (rresp_o)
   );

endmodule

// ==== verification/tb_mem_tasks.svh ====
// directed tests and AXI4-Lite channel drivers for the memory subsystem
// inputs change on the rising edge, outputs are sampled on the falling edge

task automatic check_eq(input string name, input data_t exp, input data_t act);
   assert (act === exp) else begin
      $display("Mismatch at %0d ns: %s expected %h got %h", $time, name, exp, act);
      abort_run();
   end
endtask

task automatic timed_out(input string what);
   $display("Timeout at %0d ns while waiting for %s", $time, what);
   abort_run();
endtask

// old word with the strobed bytes taken from the new one
function automatic data_t merge_bytes(input data_t old_d, input data_t new_d, input strb_t s);
   data_t m;
   m = old_d;
   for (int b = 0; b < STRB_W; b++) begin
      if (s[b])
         m[8*b +: 8] = new_d[8*b +: 8];
   end
   return m;
endfunction

task automatic send_aw(input addr_t a);
   int n;
   @(posedge clk);
   awvalid <= 1'b1;
   awaddr  <= a;
   n = 0;
   do begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) timed_out("awready_o");
   end while (!awready);
   @(posedge clk); // transfer on this edge
   awvalid <= 1'b0;
endtask

task automatic send_w(input data_t d, input strb_t s);
   int n;
   @(posedge clk);
   wvalid <= 1'b1;
   wdata  <= d;
   wstrb  <= s;
   n = 0;
   do begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) timed_out("wready_o");
   end while (!wready);
   @(posedge clk);
   wvalid <= 1'b0;
endtask

task automatic send_ar(input addr_t a);
   int n;
   @(posedge clk);
   arvalid <= 1'b1;
   araddr  <= a;
   n = 0;
   do begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) timed_out("arready_o");
   end while (!arready);
   @(posedge clk);
   arvalid <= 1'b0;
endtask

// bready stays high, so the response is taken on the next edge
task automatic wait_b(output resp_t r);
   int n;
   n = 0;
   do begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) timed_out("bvalid_o");
   end while (!bvalid);
   r = bresp;
   @(posedge clk);
endtask

task automatic wait_r(output data_t d, output resp_t r);
   int n;
   n = 0;
   do begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) timed_out("rvalid_o");
   end while (!rvalid);
   d = rdata;
   r = rresp;
   @(posedge clk);
endtask

task automatic write_word(input addr_t a, input data_t d, input strb_t s, input resp_t exp);
   resp_t r;
   send_aw(a);
   send_w(d, s);
   wait_b(r);
   check_eq("bresp_o", data_t'(exp), data_t'(r));
endtask

task automatic read_word(input addr_t a, input data_t exp_d, input resp_t exp_r);
   data_t d;
   resp_t r;
   send_ar(a);
   wait_r(d, r);
   check_eq("rresp_o", data_t'(exp_r), data_t'(r));
   check_eq("rdata_o", exp_d, d);
endtask

task automatic test_reset_state();
   @(negedge clk);
   check_eq("bvalid_o", '0, data_t'(bvalid));
   check_eq("rvalid_o", '0, data_t'(rvalid));
   check_eq("awready_o", data_t'(1), data_t'(awready));
   check_eq("wready_o", data_t'(1), data_t'(wready));
   check_eq("arready_o", data_t'(1), data_t'(arready));
endtask

task automatic test_windows();
   addr_t bases [3];
   data_t vals [3];
   data_t r;
   addr_t off;
   bases[0] = BOOT_BASE;
   bases[1] = SHARED_BASE;
   bases[2] = MAIN_BASE;
   rand_bits(9, r);
   off = addr_t'(r[8:0]) << 3; // same word in every window
   for (int i = 0; i < 3; i++) begin
      rand_bits(64, vals[i]);
      write_word(bases[i] + off, vals[i], '1, RESP_OKAY);
   end
   // read after all three writes, so aliasing would show
   for (int i = 0; i < 3; i++) begin
      read_word(bases[i] + off, vals[i], RESP_OKAY);
   end
endtask

task automatic test_strobes();
   data_t first;
   data_t second;
   data_t r;
   addr_t a;
   strb_t s;
   for (int k = 0; k < 2; k++) begin
      rand_bits(11, r);
      a = MAIN_BASE + (addr_t'(r[10:0]) << 3);
      rand_bits(64, first);
      rand_bits(64, second);
      rand_bits(8, r);
      s = (k == 0) ? 8'h3c : r[7:0];
      write_word(a, first, '1, RESP_OKAY);
      write_word(a, second, s, RESP_OKAY);
      read_word(a, merge_bytes(first, second, s), RESP_OKAY);
   end
endtask

task automatic test_unmapped();
   addr_t limits [3];
   data_t keep;
   data_t junk;
   limits[0] = BOOT_BASE + addr_t'(BOOT_WORDS * 8);    // first byte past each window
   limits[1] = SHARED_BASE + addr_t'(SHARED_WORDS * 8);
   limits[2] = MAIN_BASE + addr_t'(MAIN_WORDS * 8);
   for (int i = 0; i < 3; i++) begin
      rand_bits(64, keep);
      rand_bits(64, junk);
      write_word(limits[i] - 8, keep, '1, RESP_OKAY);
      write_word(limits[i], junk, '1, RESP_DECERR);
      read_word(limits[i], '0, RESP_DECERR);
      read_word(limits[i] - 8, keep, RESP_OKAY);
   end
   rand_bits(64, junk);
   write_word('0, junk, '1, RESP_DECERR);
   read_word('0, '0, RESP_DECERR);
endtask

task automatic test_backpressure();
   data_t want [4];
   data_t r;
   data_t held;
   data_t d;
   resp_t rr;
   addr_t a;
   int    n;
   rand_bits(7, r);
   a = SHARED_BASE + (addr_t'(r[6:0]) << 3);
   for (int i = 0; i < 4; i++) begin
      rand_bits(64, want[i]);
      write_word(a + addr_t'(i * 8), want[i], '1, RESP_OKAY);
   end
   @(posedge clk);
   rready <= 1'b0;
   // two reads fill the result queue, two more wait in the AR slice
   for (int i = 0; i < 4; i++) begin
      send_ar(a + addr_t'(i * 8));
   end
   n = 0;
   do begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) timed_out("rvalid_o under back-pressure");
   end while (!rvalid);
   held = rdata;
   check_eq("rdata_o", want[0], held);
   repeat (6) begin
      @(negedge clk);
      check_eq("rvalid_o", data_t'(1), data_t'(rvalid));
      check_eq("rdata_o", held, rdata);
      check_eq("rresp_o", data_t'(RESP_OKAY), data_t'(rresp));
   end
   check_eq("arready_o", '0, data_t'(arready)); // slice full behind the queue
   @(posedge clk);
   rready <= 1'b1;
   for (int i = 0; i < 4; i++) begin
      wait_r(d, rr);
      check_eq("rresp_o", data_t'(RESP_OKAY), data_t'(rr));
      check_eq("rdata_o", want[i], d);
   end
endtask

task automatic test_aw_w_order();
   addr_t a0;
   addr_t a1;
   data_t d0;
   data_t d1;
   data_t r;
   resp_t br;
   rand_bits(11, r);
   a0 = MAIN_BASE + (addr_t'(r[10:0]) << 3);
   a1 = a0 ^ 32'h8; // neighbouring word
   rand_bits(64, d0);
   rand_bits(64, d1);
   send_aw(a0);
   repeat (3) begin
      @(negedge clk);
      check_eq("bvalid_o", '0, data_t'(bvalid)); // address alone does not issue
   end
   send_w(d0, '1);
   wait_b(br);
   check_eq("bresp_o", data_t'(RESP_OKAY), data_t'(br));
   send_w(d1, '1);
   repeat (3) begin
      @(negedge clk);
      check_eq("bvalid_o", '0, data_t'(bvalid));
   end
   send_aw(a1);
   wait_b(br);
   check_eq("bresp_o", data_t'(RESP_OKAY), data_t'(br));
   read_word(a0, d0, RESP_OKAY);
   read_word(a1, d1, RESP_OKAY);
endtask

// ==== verification/tb_mem_subsys.sv ====
// testbench top for the on-chip memory subsystem
// clock, reset, DUT and the directed test sequence

`timescale 1ns/1ps

module tb_mem_subsys import mem_pkg::*; ();

   localparam int WAIT_LIMIT = 200; // cycles allowed per wait

   logic        clk;
   logic        rst_n;
   logic        awvalid;
   logic        awready;
   addr_t       awaddr;
   logic        wvalid;
   logic        wready;
   data_t       wdata;
   strb_t       wstrb;
   logic        bvalid;
   logic        bready;
   resp_t       bresp;
   logic        arvalid;
   logic        arready;
   addr_t       araddr;
   logic        rvalid;
   logic        rready;
   data_t       rdata;
   resp_t       rresp;
   logic [31:0] lfsr_q;

   mem_subsys_top i_mem_subsys_top (
      .clk_i     (clk),
      .rst_ni    (rst_n),
      .awvalid_i (awvalid),
      .awready_o (awready),
      .awaddr_i  (awaddr),
      .wvalid_i  (wvalid),
      .wready_o  (wready),
      .wdata_i   (wdata),
      .wstrb_i   (wstrb),
      .bvalid_o  (bvalid),
      .bready_i  (bready),
      .bresp_o   (bresp),
      .arvalid_i (arvalid),
      .arready_o (arready),
      .araddr_i  (araddr),
      .rvalid_o  (rvalid),
      .rready_i  (rready),
      .rdata_o   (rdata),
      .rresp_o   (rresp)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk; // 40 ns period
   end

   task automatic abort_run();
      $display("Simulation failed");
      $fatal(1, "run stopped at first error");
   endtask

   // x^32 + x^22 + x^2 + x + 1, shifted left
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // one lfsr step per bit taken
   task automatic rand_bits(input int n, output data_t v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_next(lfsr_q);
         v = {v[DATA_W-2:0], lfsr_q[0]};
      end
   endtask

`include "tb_mem_tasks.svh"

   initial begin
      rst_n   = 1'b0;
      awvalid = 1'b0;
      awaddr  = '0;
      wvalid  = 1'b0;
      wdata   = '0;
      wstrb   = '0;
      bready  = 1'b1;
      arvalid = 1'b0;
      araddr  = '0;
      rready  = 1'b1;
      lfsr_q  = 32'd88775;
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      test_reset_state();
      test_windows();
      test_strobes();
      test_unmapped();
      test_backpressure();
      test_aw_w_order();
      $display("Simulation passed");
      $finish;
   end

endmodule

// ==== verilog.f ====
+incdir+verification
common/mem_pkg.sv
design/axil_front/axil_req_slice.sv
design/axil_front/axil_front.sv
design/bram_bank.sv
design/mem_router.sv
design/axil_resp.sv
design/mem_subsys_top.sv
verification/tb_mem_subsys.sv
